/* list.f */
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fe_pcgen.sv
hdl/fe_skid_buf.sv
hdl/fe_fetch.sv
hdl/fe_decode.sv
hdl/fe_fifo.sv
hdl/fe_top.sv
sim/fe_clkgen.sv
sim/fe_checker.sv
sim/fe_tb.sv

/* imem.hex */
// one 32-bit instruction word per line, hex, rom index 0 to 31
// opcode class in bits 31..28, rd in bits 4..0
00000001
10a30002
2f000000
3123401f
40000085
40100000
50210003
60000010
7000000a
70000000
80000000
80000001
90000004
a1234567
0000000c
1abcdef6
20000007
4400001e
5500000f
6600001b
77777771
80000000
88000000
b0000002
c0000003
d0000004
e0000005
f0000006
30000008
40000009
7000001f
00000000

/* sim/fe_tb.sv */
`timescale 1ns/10ps

module fe_tb
  import frontend_pkg::*;
();

  localparam int NUM_PKTS   = 400;
  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT_NS = NUM_PKTS * CLK_PERIOD * 20;

  logic       clk;
  logic       rst_n;
  redirect_t  redirect;
  logic       pkg_valid;
  logic       pkg_ready;
  fe_pkt_t    pkg;
  int         mismatches;
  int         pkt_count;
  logic [6:0] op_seen;
  logic       upper_seen;
  int         other_errors;
  int         redirects;
  fe_op_e     op_class;

  fe_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clkgen (
    .clk(clk), .rst_n(rst_n)
  );

  fe_top UUT (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect),
    .pkg_valid_o(pkg_valid), .pkg_ready_i(pkg_ready), .pkg_o(pkg)
  );

  fe_checker u_checker (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect),
    .pkg_valid_i(pkg_valid), .pkg_ready_i(pkg_ready), .pkg_i(pkg),
    .err_count_o(mismatches), .pkt_count_o(pkt_count),
    .op_seen_o(op_seen), .upper_seen_o(upper_seen)
  );

  // back-pressure and redirect pulses
  initial
  begin
    void'($urandom(14));
    pkg_ready  = 1'b0;
    redirect   = '0;
    redirects  = 0;
    @(posedge rst_n);
    forever
    begin
      @(posedge clk);
      #1;
      pkg_ready = ($urandom % 10) < 7;
      // the reset pc packet goes out before any redirect
      if (!redirect.valid && pkt_count > 0 && ($urandom % 40) == 0)
      begin
        redirect.valid = 1'b1;
        // every other target lands on the upper word
        redirect.pc = ($urandom & 32'hffff_fff8) | (redirects[0] ? 32'h4 : 32'h0);
        redirects++;
      end
      else
        redirect = '0;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("error: timeout after %0d ns, %0d of %0d packets checked",
             TIMEOUT_NS, pkt_count, NUM_PKTS);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    other_errors = 0;
    wait (pkt_count >= NUM_PKTS);
    @(posedge clk);
    for (int i = 0; i < 7; i++)
    begin
      if (!op_seen[i])
      begin
        other_errors++;
        op_class = fe_op_e'(i);
        $display("error: opcode class %s never appeared", op_class.name());
      end
    end
    if (!upper_seen)
    begin
      other_errors++;
      $display("error: no packet starting on an upper word was checked");
    end
    $display("packets %0d, redirects %0d, check errors %0d, coverage errors %0d",
             pkt_count, redirects, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* sim/fe_checker.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module fe_checker
  import frontend_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  redirect_t  redirect_i,
  input  logic       pkg_valid_i,
  input  logic       pkg_ready_i,
  input  fe_pkt_t    pkg_i,
  output int         err_count_o,
  output int         pkt_count_o,
  output logic [6:0] op_seen_o,
  output logic       upper_seen_o
);

  logic [31:0] rom [`FE_ROM_WORDS];
  logic [31:0] exp_pc;
  logic        flush_d;

  initial
  begin
    $readmemh("imem.hex", rom);
    err_count_o  = 0;
    pkt_count_o  = 0;
    op_seen_o    = '0;
    upper_seen_o = 1'b0;
    exp_pc       = `FE_RESET_PC;
    flush_d      = 1'b0;
  end

  function automatic fe_op_e ref_op(input logic [31:0] inst);
    logic [3:0] top;
    top = inst[31:28];
    if (top <= 4'd3)
      return OP_ALU;
    if (top == 4'd4)
      return OP_LOAD;
    if (top == 4'd5)
      return OP_STORE;
    if (top == 4'd6)
      return OP_BRANCH;
    if (top == 4'd7)
      return OP_JUMP;
    if (top == 4'd8 && inst[27:0] == 28'd0)
      return OP_SYS;
    return OP_ILLEGAL;
  endfunction

  // one slot from its own pc, rom wraps on the word index
  function automatic dec_slot_t ref_slot(input logic [31:0] spc);
    dec_slot_t s;
    s.pc        = spc;
    s.inst      = rom[(spc >> 2) % `FE_ROM_WORDS];
    s.op        = ref_op(s.inst);
    s.rd        = s.inst[4:0];
    s.writes_rd = (s.op == OP_ALU || s.op == OP_LOAD || s.op == OP_JUMP) && (s.rd != 5'd0);
    return s;
  endfunction

  function automatic fe_pkt_t expected_pkt(input logic [31:0] pc);
    fe_pkt_t p;
    p         = '0;
    p.slot[0] = ref_slot(pc);
    if (pc[2])
      p.mask = 2'b01;
    else
    begin
      p.mask    = 2'b11;
      p.slot[1] = ref_slot(pc | 32'h4);
    end
    return p;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      err_count_o++;
      $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic compare_pkt(input fe_pkt_t exp_p, input fe_pkt_t act_p);
    check_field("pkg_o.mask", 32'(exp_p.mask), 32'(act_p.mask));
    for (int i = 0; i < 2; i++)
    begin
      // unused slots carry stale data
      if (exp_p.mask[i])
      begin
        check_field($sformatf("pkg_o.slot[%0d].pc", i), exp_p.slot[i].pc, act_p.slot[i].pc);
        check_field($sformatf("pkg_o.slot[%0d].inst", i), exp_p.slot[i].inst,
                    act_p.slot[i].inst);
        check_field($sformatf("pkg_o.slot[%0d].op", i), 32'(exp_p.slot[i].op),
                    32'(act_p.slot[i].op));
        check_field($sformatf("pkg_o.slot[%0d].rd", i), 32'(exp_p.slot[i].rd),
                    32'(act_p.slot[i].rd));
        check_field($sformatf("pkg_o.slot[%0d].writes_rd", i), 32'(exp_p.slot[i].writes_rd),
                    32'(act_p.slot[i].writes_rd));
        op_seen_o[exp_p.slot[i].op] = 1'b1;
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_pc  = `FE_RESET_PC;
      flush_d = 1'b0;
      if (pkg_valid_i)
      begin
        err_count_o++;
        $display("error: pkg_valid_o is high during reset at %0t", $time);
      end
    end
    else
    begin
      if (pkg_valid_i && (redirect_i.valid || flush_d))
      begin
        err_count_o++;
        $display("error: pkg_valid_o is high in or right after a redirect at %0t", $time);
      end
      else if (pkg_valid_i && pkg_ready_i)
      begin
        compare_pkt(expected_pkt(exp_pc), pkg_i);
        if (exp_pc[2])
          upper_seen_o = 1'b1;
        exp_pc = (exp_pc & ~32'h7) + 32'd8;
        pkt_count_o++;
      end
      if (redirect_i.valid)
        exp_pc = redirect_i.pc;
      flush_d = redirect_i.valid;
    end
  end

endmodule

/* sim/fe_clkgen.sv */
`timescale 1ns/10ps

module fe_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* hdl/fe_top.sv */
`timescale 1ns/10ps

module fe_top
  import frontend_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  redirect_t redirect_i,
  output logic      pkg_valid_o,
  input  logic      pkg_ready_i,
  output fe_pkt_t   pkg_o
);

  logic       flush;
  logic       p_valid, p_ready, f_in_valid, f_in_ready;
  logic       f_valid, f_ready, d_in_valid, d_in_ready;
  logic       d_valid, d_ready;
  pc_req_t    p_req, f_req;
  fetch_pkt_t f_pkt, d_pkt;
  fe_pkt_t    d_out;

  assign flush = redirect_i.valid;

  fe_pcgen u_pcgen (
    .clk(clk), .rst_n(rst_n), .flush_i(flush), .redirect_pc_i(redirect_i.pc),
    .ready_i(p_ready), .valid_o(p_valid), .req_o(p_req)
  );

  fe_skid_buf #(.payload_t(pc_req_t)) u_skid_pf (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(p_valid), .ready_o(p_ready), .data_i(p_req),
    .valid_o(f_in_valid), .ready_i(f_in_ready), .data_o(f_req)
  );

  fe_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(f_in_valid), .ready_o(f_in_ready), .req_i(f_req),
    .valid_o(f_valid), .ready_i(f_ready), .pkt_o(f_pkt)
  );

  fe_skid_buf #(.payload_t(fetch_pkt_t)) u_skid_fd (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(f_valid), .ready_o(f_ready), .data_i(f_pkt),
    .valid_o(d_in_valid), .ready_i(d_in_ready), .data_o(d_pkt)
  );

  fe_decode u_decode (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(d_in_valid), .ready_o(d_in_ready), .pkt_i(d_pkt),
    .valid_o(d_valid), .ready_i(d_ready), .pkt_o(d_out)
  );

  fe_fifo u_fifo (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .valid_i(d_valid), .ready_o(d_ready), .data_i(d_out),
    .valid_o(pkg_valid_o), .ready_i(pkg_ready_i), .data_o(pkg_o)
  );

endmodule

/* hdl/fe_fifo.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module fe_fifo
  import frontend_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    flush_i,
  input  logic    valid_i,
  output logic    ready_o,
  input  fe_pkt_t data_i,
  output logic    valid_o,
  input  logic    ready_i,
  output fe_pkt_t data_o
);

  localparam int DEPTH = `FE_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  fe_pkt_t       mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign ready_o = (count != CW'(DEPTH));
  // nothing leaves while the pipe is being flushed
  assign valid_o = (count != '0) && !flush_i;
  assign data_o  = mem[rd_ptr];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= data_i;
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CW'(DEPTH));
  // empty and full both leave the pointers equal
  a_ptr_match: assert property (@(posedge clk) disable iff (!rst_n)
    (count == '0 || count == CW'(DEPTH)) |-> wr_ptr == rd_ptr);

endmodule

/* hdl/fe_decode.sv */
`timescale 1ns/10ps

module fe_decode
  import frontend_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  logic       valid_i,
  output logic       ready_o,
  input  fetch_pkt_t pkt_i,
  output logic       valid_o,
  input  logic       ready_i,
  output fe_pkt_t    pkt_o
);

  logic       valid_q;
  fetch_pkt_t d_q;

  function automatic fe_op_e classify(input logic [31:0] inst);
    fe_op_e op;
    case (inst[31:28])
      4'h0, 4'h1, 4'h2, 4'h3: op = OP_ALU;
      4'h4:    op = OP_LOAD;
      4'h5:    op = OP_STORE;
      4'h6:    op = OP_BRANCH;
      4'h7:    op = OP_JUMP;
      // sys needs an all-zero body
      4'h8:    op = (inst[27:0] == 28'd0) ? OP_SYS : OP_ILLEGAL;
      default: op = OP_ILLEGAL;
    endcase
    return op;
  endfunction

  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (ready_o)
      d_q <= pkt_i;
  end

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      pkt_o.slot[i].inst      = d_q.inst[i];
      pkt_o.slot[i].op        = classify(d_q.inst[i]);
      pkt_o.slot[i].rd        = d_q.inst[i][4:0];
      pkt_o.slot[i].writes_rd = (pkt_o.slot[i].op inside {OP_ALU, OP_LOAD, OP_JUMP})
                                && (d_q.inst[i][4:0] != 5'd0);
    end
    pkt_o.slot[0].pc = d_q.pc;
    pkt_o.slot[1].pc = {d_q.pc[31:3], 1'b1, d_q.pc[1:0]};
    pkt_o.mask       = d_q.mask;
  end

  assign valid_o = valid_q;

endmodule

/* hdl/fe_fetch.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module fe_fetch
  import frontend_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  logic       valid_i,
  output logic       ready_o,
  input  pc_req_t    req_i,
  output logic       valid_o,
  input  logic       ready_i,
  output fetch_pkt_t pkt_o
);

  localparam int AW = $clog2(`FE_ROM_WORDS);

  logic [31:0]      rom [`FE_ROM_WORDS];
  logic             valid_q;
  logic [31:0]      pc_q;
  logic [1:0]       mask_q;
  logic [1:0][31:0] inst_q;
  logic             accept;

  initial $readmemh("imem.hex", rom);

  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      valid_q <= 1'b0;
    else if (accept)
      valid_q <= 1'b1;
    else if (ready_i)
      valid_q <= 1'b0;
  end

  // both words of the aligned pair, wraps over the rom
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      inst_q[0] <= rom[{req_i.pc[AW+1:3], 1'b0}];
      inst_q[1] <= rom[{req_i.pc[AW+1:3], 1'b1}];
      pc_q      <= req_i.pc;
      mask_q    <= req_i.mask;
    end
  end

  always_comb
  begin
    pkt_o.pc   = pc_q;
    pkt_o.inst = inst_q;
    pkt_o.mask = mask_q;
    // upper word only, move it down to slot 0
    if (!mask_q[0])
    begin
      pkt_o.inst[0] = inst_q[1];
      pkt_o.mask    = {1'b0, mask_q[1]};
    end
  end

  assign valid_o = valid_q;

endmodule

/* hdl/fe_skid_buf.sv */
`timescale 1ns/10ps

module fe_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     ready_q;
  payload_t data_q;

  // drops to low only while an entry is parked
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      ready_q <= 1'b1;
    else
      ready_q <= !(valid_o && !ready_i);
  end

  always_ff @(posedge clk)
  begin
    if (ready_q)
      data_q <= data_i;
  end

  assign ready_o = ready_q;
  assign valid_o = valid_i || !ready_q;
  assign data_o  = ready_q ? data_i : data_q;

  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

/* hdl/fe_pcgen.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module fe_pcgen
  import frontend_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        ready_i,
  output logic        valid_o,
  output pc_req_t     req_o
);

  logic [31:0] pc_q;
  logic        valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= `FE_RESET_PC;
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      pc_q    <= redirect_pc_i;
      valid_q <= 1'b1;
    end
    else
    begin
      valid_q <= 1'b1;
      // step to the next aligned pair
      if (valid_q && ready_i)
        pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  assign valid_o    = valid_q;
  assign req_o.pc   = pc_q;
  assign req_o.mask = pc_q[2] ? 2'b10 : 2'b11;

  // redirect targets from the backend must be word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    valid_q |-> pc_q[1:0] == 2'b00);

endmodule

/* hdl/frontend_pkg.sv */
package frontend_pkg;

  typedef enum logic [2:0] {
    OP_ALU     = 3'd0,
    OP_LOAD    = 3'd1,
    OP_STORE   = 3'd2,
    OP_BRANCH  = 3'd3,
    OP_JUMP    = 3'd4,
    OP_SYS     = 3'd5,
    OP_ILLEGAL = 3'd6
  } fe_op_e;

  // one-cycle pulse from the backend
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [1:0]  mask;
  } pc_req_t;

  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] inst;
    logic [1:0]       mask;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    fe_op_e      op;
    logic [4:0]  rd;
    logic        writes_rd;
  } dec_slot_t;

  typedef struct packed {
    dec_slot_t [1:0] slot;
    logic [1:0]      mask;
  } fe_pkt_t;

endpackage

/* hdl/frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// first fetch address, must stay 8-byte aligned
`define FE_RESET_PC 32'h0000_1000

// rom depth in words, indexed by pc[6:2]
`define FE_ROM_WORDS 32

// output queue entries
`define FE_FIFO_DEPTH 8

`endif
